//--- src/csi2_hdr_pkg.sv
/*
 * Shared types for the CSI-2 header check path.
 * The port field of hdr_out_t is 4 bits wide, so at most 16 ports.
 */
package csi2_hdr_pkg;

    localparam int PORT_W = 4;

    typedef logic [PORT_W-1:0] port_idx_t;

    // CSI-2 column code of each header data bit
    localparam logic [5:0] ecc_col_tbl [24] = '{
        6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15,
        6'h16, 6'h19, 6'h1a, 6'h1c, 6'h23, 6'h25,
        6'h26, 6'h29, 6'h2a, 6'h2c, 6'h31, 6'h32,
        6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b
    };

    // data is {word count, data identifier}
    typedef struct packed {
        logic [23:0] data;
        logic [5:0]  ecc;
    } hdr_word_t;

    typedef struct packed {
        logic [23:0] data;
        logic        error;
        logic        corrected;
    } hdr_chk_t;

    typedef enum logic [2:0] {
        frame_start,
        frame_end,
        line_start,
        line_end,
        generic_short,
        long_pkt,
        reserved_type,
        bad_header
    } pkt_kind_t;

    typedef struct packed {
        port_idx_t   port;
        logic [1:0]  vc;
        logic [5:0]  data_type;
        logic [15:0] word_count;
        logic        error;
        logic        corrected;
        pkt_kind_t   kind;
    } hdr_out_t;

endpackage

//--- src/csi2_hdr_assemble.sv
/*
 * Byte-to-header assembly, one lane per port.
 * A start strobe restarts a port at byte 0. ECC bits 7..6 are ignored.
 */
module csi2_hdr_assemble #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic [NUM_PORTS-1:0][7:0]                  lane_byte,
    input  logic [NUM_PORTS-1:0]                       lane_valid,
    input  logic [NUM_PORTS-1:0]                       lane_start,
    output csi2_hdr_pkg::hdr_word_t [NUM_PORTS-1:0]    hdr,
    output logic [NUM_PORTS-1:0]                       hdr_valid
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic [1:0]              cnt;
        logic [23:0]             part;
        logic                    word_valid;
        csi2_hdr_pkg::hdr_word_t word;

        // cnt holds the index of the next byte and 0 means idle
        always_ff @(posedge clk) begin
            if (reset) begin
                cnt        <= 2'd0;
                word_valid <= 1'b0;
            end else begin
                word_valid <= 1'b0;
                if (lane_valid[p]) begin
                    if (lane_start[p] || cnt == 2'd0) begin
                        cnt <= 2'd1;
                    end else begin
                        // wraps back to idle after the ecc byte
                        cnt        <= cnt + 2'd1;
                        word_valid <= (cnt == 2'd3);
                    end
                end
            end
        end

        always_ff @(posedge clk) begin
            if (lane_valid[p]) begin
                if (lane_start[p] || cnt == 2'd0) begin
                    part[7:0] <= lane_byte[p];
                end else begin
                    case (cnt)
                        2'd1: part[15:8]  <= lane_byte[p];
                        2'd2: part[23:16] <= lane_byte[p];
                        default: begin
                            word.data <= part;
                            word.ecc  <= lane_byte[p][5:0];
                        end
                    endcase
                end
            end
        end

        assign hdr[p]       = word;
        assign hdr_valid[p] = word_valid;
    end

endmodule

//--- src/csi2_ecc24_check.sv
/*
 * CSI-2 header ECC check for one port, five register stages.
 * Corrects one flipped bit and flags anything worse as uncorrectable.
 */
module csi2_ecc24_check (
    input  logic                    clk,
    input  logic                    reset,
    input  csi2_hdr_pkg::hdr_word_t in,
    input  logic                    in_valid,
    output csi2_hdr_pkg::hdr_chk_t  out,
    output logic                    out_valid
);

    csi2_hdr_pkg::hdr_word_t st0_hdr;

    logic [23:0] st1_data;
    logic [5:0]  st1_recv_ecc;
    logic [5:0]  st1_calc_ecc;

    logic [23:0] st2_data;
    logic [5:0]  st2_syndrome;

    logic [23:0] st3_data;
    logic [23:0] st3_mask;
    logic        st3_error;
    logic        st3_ecc_only;

    csi2_hdr_pkg::hdr_chk_t st4_chk;

    logic [4:0]  valid_sr;

    logic [5:0]  calc_ecc;
    logic [23:0] fix_mask;

    // ------------------------------------------------------------------
    // combinational helpers
    // ------------------------------------------------------------------

    // parity fold over the set data bits
    always_comb begin
        calc_ecc = 6'd0;
        for (int i = 0; i < 24; i++) begin
            if (st0_hdr.data[i]) begin
                calc_ecc = calc_ecc ^ csi2_hdr_pkg::ecc_col_tbl[i];
            end
        end
    end

    // a syndrome equal to a column code points at that data bit
    always_comb begin
        for (int i = 0; i < 24; i++) begin
            fix_mask[i] = (st2_syndrome == csi2_hdr_pkg::ecc_col_tbl[i]);
        end
    end

    // ------------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        // stage 0
        st0_hdr <= in;

        // stage 1
        st1_data     <= st0_hdr.data;
        st1_recv_ecc <= st0_hdr.ecc;
        st1_calc_ecc <= calc_ecc;

        // stage 2
        st2_data     <= st1_data;
        st2_syndrome <= st1_recv_ecc ^ st1_calc_ecc;

        // stage 3
        st3_data     <= st2_data;
        st3_mask     <= fix_mask;
        st3_error    <= (st2_syndrome != 6'd0);
        st3_ecc_only <= $onehot(st2_syndrome);

        // stage 4
        st4_chk.data      <= st3_data ^ st3_mask;
        st4_chk.error     <= st3_error;
        st4_chk.corrected <= st3_ecc_only || (st3_mask != 24'd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= 5'd0;
        end else begin
            valid_sr <= {valid_sr[3:0], in_valid};
        end
    end

    assign out       = st4_chk;
    assign out_valid = valid_sr[4];

endmodule

//--- src/csi2_hdr_merge.sv
/*
 * Round-robin drain of per-port checker results, two entries per port.
 * No back-pressure. A result that meets a full queue is lost and overflow sticks.
 */
module csi2_hdr_merge #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  csi2_hdr_pkg::hdr_chk_t [NUM_PORTS-1:0]   chk,
    input  logic [NUM_PORTS-1:0]                     chk_valid,
    output csi2_hdr_pkg::hdr_out_t                   out,
    output logic                                     out_valid,
    output logic                                     overflow
);

    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    csi2_hdr_pkg::hdr_chk_t q_mem [NUM_PORTS][2];
    logic [1:0]             q_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0]   wr_ptr;
    logic [NUM_PORTS-1:0]   rd_ptr;
    logic [NUM_PORTS-1:0]   push;
    logic [NUM_PORTS-1:0]   pop;
    logic [NUM_PORTS-1:0]   full;
    logic [PORT_W-1:0]      rr_ptr;
    logic [PORT_W-1:0]      grant;
    logic                   grant_valid;
    csi2_hdr_pkg::hdr_chk_t head;

    function automatic csi2_hdr_pkg::pkt_kind_t decode_kind(input csi2_hdr_pkg::hdr_chk_t h);
        logic [5:0] dt;
        dt = h.data[5:0];
        if (h.error && !h.corrected) begin
            return csi2_hdr_pkg::bad_header;
        end
        case (dt)
            6'h00: return csi2_hdr_pkg::frame_start;
            6'h01: return csi2_hdr_pkg::frame_end;
            6'h02: return csi2_hdr_pkg::line_start;
            6'h03: return csi2_hdr_pkg::line_end;
            default: begin
                if (dt >= 6'h10) begin
                    return csi2_hdr_pkg::long_pkt;
                end else if (dt >= 6'h08) begin
                    return csi2_hdr_pkg::generic_short;
                end
                return csi2_hdr_pkg::reserved_type;
            end
        endcase
    endfunction

    // ------------------------------------------------------------------
    // arbitration with the search starting at rr_ptr
    // ------------------------------------------------------------------

    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant       = rr_ptr;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_PORTS;
            if (!grant_valid && q_cnt[idx] != 2'd0) begin
                grant_valid = 1'b1;
                grant       = PORT_W'(idx);
            end
        end
    end

    always_comb begin
        pop        = '0;
        pop[grant] = grant_valid;
        for (int p = 0; p < NUM_PORTS; p++) begin
            // a pop on the same edge frees the slot
            full[p] = (q_cnt[p] == 2'd2) && !pop[p];
            push[p] = chk_valid[p] && !full[p];
        end
    end

    assign head = q_mem[grant][rd_ptr[grant]];

    // ------------------------------------------------------------------
    // queues and output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (push[p]) begin
                q_mem[p][wr_ptr[p]] <= chk[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rr_ptr    <= '0;
            out_valid <= 1'b0;
            overflow  <= 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                q_cnt[p] <= 2'd0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (push[p]) begin
                    wr_ptr[p] <= ~wr_ptr[p];
                end
                if (pop[p]) begin
                    rd_ptr[p] <= ~rd_ptr[p];
                end
                q_cnt[p] <= q_cnt[p] + 2'(push[p]) - 2'(pop[p]);
                if (chk_valid[p] && full[p]) begin
                    overflow <= 1'b1;
                end
            end
            out_valid <= grant_valid;
            if (grant_valid) begin
                rr_ptr <= (int'(grant) == NUM_PORTS - 1) ? '0 : grant + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            out.port       <= csi2_hdr_pkg::port_idx_t'(grant);
            out.vc         <= head.data[7:6];
            out.data_type  <= head.data[5:0];
            out.word_count <= head.data[23:8];
            out.error      <= head.error;
            out.corrected  <= head.corrected;
            out.kind       <= decode_kind(head);
        end
    end

endmodule

//--- src/csi2_hdr_top.sv
/*
 * Multi-port CSI-2 packet header checker.
 * Latency from byte 3 to out_valid is 7 cycles or more.
 */
module csi2_hdr_top #(
    parameter int NUM_PORTS = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [NUM_PORTS-1:0][7:0]   lane_byte,
    input  logic [NUM_PORTS-1:0]        lane_valid,
    input  logic [NUM_PORTS-1:0]        lane_start,
    output csi2_hdr_pkg::hdr_out_t      out,
    output logic                        out_valid,
    output logic                        overflow
);

    csi2_hdr_pkg::hdr_word_t [NUM_PORTS-1:0] hdr;
    logic [NUM_PORTS-1:0]                    hdr_valid;
    csi2_hdr_pkg::hdr_chk_t [NUM_PORTS-1:0]  chk;
    logic [NUM_PORTS-1:0]                    chk_valid;

    csi2_hdr_assemble #(
        .NUM_PORTS (NUM_PORTS)
    ) csi2_hdr_assemble_i (
        .clk        (clk),
        .reset      (reset),
        .lane_byte  (lane_byte),
        .lane_valid (lane_valid),
        .lane_start (lane_start),
        .hdr        (hdr),
        .hdr_valid  (hdr_valid)
    );

    // one checker pipeline per port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
        csi2_ecc24_check csi2_ecc24_check_i (
            .clk       (clk),
            .reset     (reset),
            .in        (hdr[p]),
            .in_valid  (hdr_valid[p]),
            .out       (chk[p]),
            .out_valid (chk_valid[p])
        );
    end

    csi2_hdr_merge #(
        .NUM_PORTS (NUM_PORTS)
    ) csi2_hdr_merge_i (
        .clk       (clk),
        .reset     (reset),
        .chk       (chk),
        .chk_valid (chk_valid),
        .out       (out),
        .out_valid (out_valid),
        .overflow  (overflow)
    );

endmodule

//--- verif/csi2_hdr_tb.sv
/*
 * Random-stimulus testbench for csi2_hdr_top with four ports.
 * Expected headers come from a CSI-2 ECC model, queued per port.
 */
module csi2_hdr_tb;

    localparam int NUM_PORTS     = 4;
    localparam int HDRS_PER_PORT = 60;

    logic                      clk;
    logic                      reset;
    logic [NUM_PORTS-1:0][7:0] lane_byte;
    logic [NUM_PORTS-1:0]      lane_valid;
    logic [NUM_PORTS-1:0]      lane_start;
    csi2_hdr_pkg::hdr_out_t    out;
    logic                      out_valid;
    logic                      overflow;

    integer                    seed = 41;
    csi2_hdr_pkg::hdr_out_t    exp_q [NUM_PORTS][$];
    int                        n_checked = 0;

    csi2_hdr_top #(
        .NUM_PORTS (NUM_PORTS)
    ) csi2_hdr_top_i (
        .clk        (clk),
        .reset      (reset),
        .lane_byte  (lane_byte),
        .lane_valid (lane_valid),
        .lane_start (lane_start),
        .out        (out),
        .out_valid  (out_valid),
        .overflow   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // model and helpers
    // ------------------------------------------------------------------

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [5:0] calc_ecc(input logic [23:0] data);
        logic [5:0] e;
        e = 6'd0;
        for (int i = 0; i < 24; i++) begin
            if (data[i]) begin
                e = e ^ csi2_hdr_pkg::ecc_col_tbl[i];
            end
        end
        return e;
    endfunction

    function automatic csi2_hdr_pkg::pkt_kind_t expect_kind(input logic [5:0] dt,
                                                            input logic error,
                                                            input logic corrected);
        csi2_hdr_pkg::pkt_kind_t k;
        if (error && !corrected) begin
            k = csi2_hdr_pkg::bad_header;
        end else if (dt < 6'h04) begin
            // sync codes in the order frame start, frame end, line start, line end
            case (dt[1:0])
                2'd0:    k = csi2_hdr_pkg::frame_start;
                2'd1:    k = csi2_hdr_pkg::frame_end;
                2'd2:    k = csi2_hdr_pkg::line_start;
                default: k = csi2_hdr_pkg::line_end;
            endcase
        end else if (dt < 6'h08) begin
            k = csi2_hdr_pkg::reserved_type;
        end else if (dt < 6'h10) begin
            k = csi2_hdr_pkg::generic_short;
        end else begin
            k = csi2_hdr_pkg::long_pkt;
        end
        return k;
    endfunction

    function automatic int queues_pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_hdr(input string name, input csi2_hdr_pkg::hdr_out_t want,
                             input csi2_hdr_pkg::hdr_out_t got);
        if (got !== want) begin
            fail_now($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                               $time, name, want, got));
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            fail_now($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                               $time, name, want, got));
        end
    endtask

    // ------------------------------------------------------------------
    // lane drivers on the falling edge
    // ------------------------------------------------------------------

    task automatic drive_byte(input int p, input logic [7:0] b, input logic start);
        @(negedge clk);
        lane_byte[p]  = b;
        lane_valid[p] = 1'b1;
        lane_start[p] = start;
    endtask

    task automatic drive_idle(input int p, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            lane_byte[p]  = 8'h00;
            lane_valid[p] = 1'b0;
            lane_start[p] = 1'b0;
        end
    endtask

    task automatic send_port(input int p, input int count);
        logic [23:0]            data;
        logic [29:0]            recv;
        logic [23:0]            exp_data;
        logic [7:0]             b;
        int                     nflip;
        int                     a;
        int                     c;
        int                     gap_max;
        csi2_hdr_pkg::hdr_out_t want;
        for (int h = 0; h < count; h++) begin
            // second half at full rate
            gap_max = (h < count / 2) ? 3 : 0;
            if (rand_below(8) == 0) begin
                // partial header that the next start strobe drops
                a = 1 + rand_below(3);
                for (int k = 0; k < a; k++) begin
                    drive_byte(p, 8'($random(seed)), k == 0);
                end
            end
            data  = 24'($random(seed));
            nflip = rand_below(4) % 3;
            a     = rand_below(30);
            c     = (a + 1 + rand_below(29)) % 30;
            recv  = {data, calc_ecc(data)};
            if (nflip >= 1) begin
                recv[a] = ~recv[a];
            end
            if (nflip == 2) begin
                recv[c] = ~recv[c];
            end
            // one flip is repaired and two pass through as received
            exp_data        = (nflip == 2) ? recv[29:6] : data;
            want.port       = csi2_hdr_pkg::port_idx_t'(p);
            want.vc         = exp_data[7:6];
            want.data_type  = exp_data[5:0];
            want.word_count = exp_data[23:8];
            want.error      = (nflip != 0);
            want.corrected  = (nflip == 1);
            want.kind       = expect_kind(exp_data[5:0], want.error, want.corrected);
            for (int k = 0; k < 4; k++) begin
                if (gap_max > 0) begin
                    drive_idle(p, rand_below(gap_max));
                end
                if (k == 3) begin
                    b = {2'($random(seed)), recv[5:0]};
                end else begin
                    b = recv[6 + 8 * k +: 8];
                end
                drive_byte(p, b, k == 0);
            end
            exp_q[p].push_back(want);
        end
        drive_idle(p, 1);
    endtask

    // ------------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------------

    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                check_flag("overflow", 1'b0, overflow);
                if (out_valid) begin
                    if (int'(out.port) >= NUM_PORTS) begin
                        fail_now($sformatf("output at %0t names unknown port %0d",
                                           $time, out.port));
                    end else if (exp_q[out.port].size() == 0) begin
                        fail_now($sformatf("output at %0t for port %0d, none expected",
                                           $time, out.port));
                    end else begin
                        check_hdr("out", exp_q[out.port].pop_front(), out);
                        n_checked++;
                    end
                end
            end
        end
    end

    initial begin
        int waited;
        reset      = 1'b1;
        lane_byte  = '0;
        lane_valid = '0;
        lane_start = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        fork
            send_port(0, HDRS_PER_PORT);
            send_port(1, HDRS_PER_PORT);
            send_port(2, HDRS_PER_PORT);
            send_port(3, HDRS_PER_PORT);
        join
        waited = 0;
        while (queues_pending() != 0 && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (queues_pending() != 0) begin
            $display("timeout: %0d expected headers never came out", queues_pending());
            $display("SIMULATION FAILED");
            $fatal(1, "drain timeout");
        end else begin
            // quiet period catches stray outputs
            repeat (20) @(negedge clk);
            $display("%0d headers checked", n_checked);
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- tb.f
src/csi2_hdr_pkg.sv
src/csi2_hdr_assemble.sv
src/csi2_ecc24_check.sv
src/csi2_hdr_merge.sv
src/csi2_hdr_top.sv
verif/csi2_hdr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the header checker testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module csi2_hdr_tb -f tb.f -o csi2_hdr_sim

# the simulator exits nonzero on a failed check, the log decides
./obj_dir/csi2_hdr_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi
